// File: Bender.yml
package:
  name: sya

sources:
  - rtl/sya_pkg.sv
  - rtl/sya_isa_pkg.sv
  - rtl/sya_pe.sv
  - rtl/sya_pe_array.sv
  - rtl/sya_skew.sv
  - rtl/sya_ctrl.sv
  - rtl/sya_drain.sv
  - rtl/sya_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/sya_tb.sv

// File: bench/sya_tb_cases.svh
//==========================================================================
// Test case table and reference model for the systolic engine testbench.
// Included inside the testbench module after the buffer memories.
//==========================================================================
`ifndef SYA_TB_CASES_SVH
`define SYA_TB_CASES_SVH

typedef struct packed {
    chn_t        k;
    shift_t      shift;
    zp_t         zp;
    addr_t       act_base;
    addr_t       wgt_base;
    addr_t       ofm_base;
    logic [31:0] seed;
    logic        neg;
} case_t;

localparam int NUM_CASES = 7;

// Columns: K, shift, zp, act base, wgt base, ofm base, data seed, all-negative
case_t case_tab [NUM_CASES] = '{
    '{16'd1,  5'd0, 8'h00, 16'h0000, 16'h1000, 16'h2000, 32'h0000_0001, 1'b0},
    '{16'd3,  5'd2, 8'h10, 16'h0100, 16'h1100, 16'h2100, 32'h0000_0042, 1'b0},
    '{16'd16, 5'd6, 8'h05, 16'hfff8, 16'h1200, 16'h2200, 32'h0000_1234, 1'b0},
    '{16'd16, 5'd0, 8'h80, 16'h0300, 16'h1300, 16'h2300, 32'h0000_7777, 1'b1},
    '{16'd16, 5'd9, 8'he0, 16'h0400, 16'h1400, 16'hfffe, 32'h0000_beef, 1'b0},
    '{16'd3,  5'd0, 8'h21, 16'h0500, 16'h1500, 16'h2500, 32'h0000_0c0d, 1'b0},
    '{16'd1,  5'd1, 8'h7f, 16'h0500, 16'h1500, 16'h2500, 32'h0000_5a5a, 1'b0}
};

// Expected row r: dot products, ReLU, 8 bits from the shift position, plus zp
function automatic ofm_row_t model_row(input case_t tc, input int r);
    ofm_row_t row;
    int       sum;
    int       a;
    int       w;
    for (int c = 0; c < NUM_COL; c++) begin
        sum = 0;
        for (int i = 0; i < tc.k; i++) begin
            a = act_mem[16'(tc.act_base + i)][r];
            w = wgt_mem[16'(tc.wgt_base + i)][c];
            sum += a * w;
        end
        if (sum < 0) begin
            row[c] = 8'h00;
        end else begin
            row[c] = 8'(sum >> tc.shift) + tc.zp;
        end
    end
    return row;
endfunction

// Run length budget, 20 cycles per beat plus fixed overhead per case
function automatic int cycle_limit();
    int total;
    total = 0;
    for (int n = 0; n < NUM_CASES; n++) begin
        total += 20 * (int'(case_tab[n].k) + 16);
    end
    return total;
endfunction

`endif

// File: bench/sya_tb.sv
//==========================================================================
// Testbench for the systolic matrix engine. Models the global buffer with
// random handshakes, runs the case table back to back and checks the
// read addresses and every written output row.
//==========================================================================
module sya_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sya_pkg::*;
    import sya_isa_pkg::*;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 cfg_vld;
    logic                 cfg_rdy;
    logic [CFG_WIDTH-1:0] cfg_info;
    addr_t                act_rd_addr;
    logic                 act_rd_addr_vld;
    logic                 act_rd_addr_rdy;
    addr_t                wgt_rd_addr;
    logic                 wgt_rd_addr_vld;
    logic                 wgt_rd_addr_rdy;
    act_vec_t             act_rd_dat;
    logic                 act_rd_dat_vld;
    logic                 act_rd_dat_rdy;
    wgt_vec_t             wgt_rd_dat;
    logic                 wgt_rd_dat_vld;
    logic                 wgt_rd_dat_rdy;
    ofm_row_t             ofm_wr_dat;
    addr_t                ofm_wr_addr;
    logic                 ofm_wr_vld;
    logic                 ofm_wr_rdy;

    // Global buffer contents and reads in flight
    act_vec_t    act_mem [65536];
    wgt_vec_t    wgt_mem [65536];
    addr_t       act_q [$];
    addr_t       wgt_q [$];
    logic [31:0] hs_rng = 32'hae02;

    // Job bookkeeping shared by the monitor and the main sequence
    int       mism_cnt = 0;
    int       other_cnt = 0;
    int       cycle_cnt;
    int       iss_cnt;
    int       beat_cnt;
    int       row_cnt;
    int       cur_k;
    addr_t    cur_act_base;
    addr_t    cur_wgt_base;
    addr_t    cur_ofm_base;
    ofm_row_t exp_rows [NUM_ROW];
    logic     busy = 1'b0;
    logic     cfg_taken = 1'b0;
    logic     job_done = 1'b0;
    logic     dat_taken = 1'b0;
    logic     model_on = 1'b0;
    logic     held_vld = 1'b0;
    ofm_row_t held_dat;
    addr_t    held_addr;

    `include "sya_tb_cases.svh"

    sya_top u_sya_top (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mism_cnt++;
            $display("mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            other_cnt++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic print_counts();
        $display("Summary: %0d mismatches, %0d other errors", mism_cnt, other_cnt);
    endtask

    //==========================================================================
    // Monitor, samples every handshake on the rising edge
    //==========================================================================
    always @(posedge clk) begin : monitor
        logic act_hs;
        logic wgt_hs;
        logic beat;
        if (rst_n) begin
            model_on = 1'b1;
            act_hs   = act_rd_addr_vld & act_rd_addr_rdy;
            wgt_hs   = wgt_rd_addr_vld & wgt_rd_addr_rdy;
            beat     = act_rd_dat_vld & wgt_rd_dat_vld & act_rd_dat_rdy;
            check_true(cfg_rdy == !busy, "cfg_rdy does not follow the job state");
            check_true(act_rd_dat_rdy == wgt_rd_dat_rdy, "data readys differ");
            check_true(act_hs == wgt_hs, "address pair split across cycles");
            if (held_vld) begin
                check_true(ofm_wr_vld, "ofm_wr_vld dropped before its handshake");
                check_value("ofm_wr_dat", ofm_wr_dat, held_dat);
                check_value("ofm_wr_addr", ofm_wr_addr, held_addr);
            end
            if (cfg_vld && cfg_rdy) begin
                busy      = 1'b1;
                cfg_taken = 1'b1;
                iss_cnt   = 0;
                beat_cnt  = 0;
                row_cnt   = 0;
            end
            if (act_hs) begin
                check_true(iss_cnt < cur_k, "more than K read addresses issued");
                check_value("act_rd_addr", act_rd_addr, 16'(cur_act_base + iss_cnt));
                check_value("wgt_rd_addr", wgt_rd_addr, 16'(cur_wgt_base + iss_cnt));
                act_q.push_back(act_rd_addr);
                wgt_q.push_back(wgt_rd_addr);
                iss_cnt++;
            end
            if (beat) begin
                void'(act_q.pop_front());
                void'(wgt_q.pop_front());
                beat_cnt++;
                dat_taken = 1'b1;
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                check_true(row_cnt < NUM_ROW, "extra output row written");
                if (row_cnt < NUM_ROW) begin
                    check_value("ofm_wr_addr", ofm_wr_addr, 16'(cur_ofm_base + row_cnt));
                    check_value("ofm_wr_dat", ofm_wr_dat, exp_rows[row_cnt]);
                end
                row_cnt++;
                if (row_cnt == NUM_ROW) begin
                    check_value("act_rd_addr handshakes", iss_cnt, cur_k);
                    check_value("act_rd_dat beats", beat_cnt, cur_k);
                    busy     = 1'b0;
                    job_done = 1'b1;
                end
            end
            held_vld  = ofm_wr_vld & ~ofm_wr_rdy;
            held_dat  = ofm_wr_dat;
            held_addr = ofm_wr_addr;
        end
    end

    // Buffer model, random readys and in-order data with gaps
    always @(negedge clk) begin : buffer_model
        if (model_on) begin
            hs_rng          = lcg_step(hs_rng);
            act_rd_addr_rdy = hs_rng[31];
            wgt_rd_addr_rdy = hs_rng[30];
            ofm_wr_rdy      = hs_rng[29];
            if (!act_rd_dat_vld || dat_taken) begin
                if (act_q.size() > 0 && hs_rng[28]) begin
                    act_rd_dat     = act_mem[act_q[0]];
                    wgt_rd_dat     = wgt_mem[wgt_q[0]];
                    act_rd_dat_vld = 1'b1;
                    wgt_rd_dat_vld = 1'b1;
                end else begin
                    act_rd_dat_vld = 1'b0;
                    wgt_rd_dat_vld = 1'b0;
                end
                dat_taken = 1'b0;
            end
        end
    end

    task automatic run_case(input case_t tc);
        logic [31:0] rng;
        logic [31:0] a;
        logic [31:0] w;
        rng = 32'hae02 ^ tc.seed;
        for (int i = 0; i < tc.k; i++) begin
            rng = lcg_step(rng);
            a[31:16] = rng[31:16];
            rng = lcg_step(rng);
            a[15:0] = rng[31:16];
            rng = lcg_step(rng);
            w[31:16] = rng[31:16];
            rng = lcg_step(rng);
            w[15:0] = rng[31:16];
            // Positive activations against negative weights
            if (tc.neg) begin
                a = (a & 32'h7f7f7f7f) | 32'h01010101;
                w = w | 32'h80808080;
            end
            act_mem[16'(tc.act_base + i)] = a;
            wgt_mem[16'(tc.wgt_base + i)] = w;
        end
        for (int r = 0; r < NUM_ROW; r++) begin
            exp_rows[r] = model_row(tc, r);
        end
        cur_k        = tc.k;
        cur_act_base = tc.act_base;
        cur_wgt_base = tc.wgt_base;
        cur_ofm_base = tc.ofm_base;
        cfg_taken    = 1'b0;
        job_done     = 1'b0;
        cfg_info     = {tc.ofm_base, tc.act_base, tc.wgt_base, tc.k, tc.shift, tc.zp};
        cfg_vld      = 1'b1;
        while (!cfg_taken) @(negedge clk);
        cfg_vld = 1'b0;
        while (!job_done) @(negedge clk);
    endtask

    //==========================================================================
    // Main sequence
    //==========================================================================
    initial begin : main
        rst_n           = 1'b0;
        cfg_vld         = 1'b0;
        cfg_info        = '0;
        act_rd_addr_rdy = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        act_rd_dat      = '0;
        act_rd_dat_vld  = 1'b0;
        wgt_rd_dat      = '0;
        wgt_rd_dat_vld  = 1'b0;
        ofm_wr_rdy      = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_true(cfg_rdy, "cfg_rdy low after reset");
        check_true(!act_rd_addr_vld && !wgt_rd_addr_vld, "address valid high after reset");
        check_true(!act_rd_dat_rdy && !wgt_rd_dat_rdy, "data ready high after reset");
        check_true(!ofm_wr_vld, "ofm_wr_vld high after reset");
        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(case_tab[n]);
        end
        print_counts();
        if (mism_cnt + other_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit     = cycle_limit();
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_cnt++;
        $display("Error: run did not finish within %0d cycles", limit);
        print_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: rtl/sya_ctrl.sv
//==========================================================================
// Job controller. Latches a configuration word, issues the K read
// address pairs, counts returned beats, then flushes the array and
// hands over to the drain stage.
//==========================================================================
module sya_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_vld,
    output logic                              cfg_rdy,
    input  logic [sya_isa_pkg::CFG_WIDTH-1:0] cfg_info,
    output sya_pkg::addr_t                    act_rd_addr,
    output logic                              act_rd_addr_vld,
    input  logic                              act_rd_addr_rdy,
    output sya_pkg::addr_t                    wgt_rd_addr,
    output logic                              wgt_rd_addr_vld,
    input  logic                              wgt_rd_addr_rdy,
    input  logic                              act_rd_dat_vld,
    input  logic                              wgt_rd_dat_vld,
    output logic                              act_rd_dat_rdy,
    output logic                              wgt_rd_dat_rdy,
    output logic                              step,
    output logic                              zero_in,
    output logic                              acc_clear,
    output logic                              drain_start,
    input  logic                              drain_done,
    output sya_pkg::addr_t                    ofm_base,
    output sya_isa_pkg::shift_t               shift,
    output sya_isa_pkg::zp_t                  zp
);
    import sya_pkg::*;
    import sya_isa_pkg::*;

    localparam int FLUSH_CNT_WIDTH = $clog2(FLUSH_CYCLES);

    sya_state_e                 state;
    sya_state_e                 state_nxt;
    addr_t                      act_base;
    addr_t                      wgt_base;
    chn_t                       chn_k;
    chn_t                       iss_cnt;
    chn_t                       rcv_cnt;
    logic [FLUSH_CNT_WIDTH-1:0] flush_cnt;
    logic                       cfg_hs;
    logic                       addr_req;
    logic                       addr_hs;
    logic                       beat;
    logic                       last_beat;
    logic                       flush_end;

    assign cfg_rdy   = (state == IDLE);
    assign cfg_hs    = cfg_vld & cfg_rdy;
    assign acc_clear = cfg_hs;

    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            ofm_base <= cfg_info[OFM_LSB +: ADDR_WIDTH];
            act_base <= cfg_info[ACT_LSB +: ADDR_WIDTH];
            wgt_base <= cfg_info[WGT_LSB +: ADDR_WIDTH];
            chn_k    <= cfg_info[CHN_LSB +: CHN_WIDTH];
            shift    <= cfg_info[SHIFT_LSB +: SHIFT_WIDTH];
            zp       <= cfg_info[ZP_LSB +: ZP_WIDTH];
        end
    end

    //==========================================================================
    // Read address and data handshakes
    //==========================================================================
    // Each address valid waits on the other side's ready so the pair moves together
    assign addr_req        = (state == COMP) && (iss_cnt < chn_k);
    assign act_rd_addr_vld = addr_req & wgt_rd_addr_rdy;
    assign wgt_rd_addr_vld = addr_req & act_rd_addr_rdy;
    assign addr_hs         = addr_req & act_rd_addr_rdy & wgt_rd_addr_rdy;
    assign act_rd_addr     = act_base + iss_cnt;
    assign wgt_rd_addr     = wgt_base + iss_cnt;

    assign act_rd_dat_rdy = (state == COMP) && (rcv_cnt < chn_k);
    assign wgt_rd_dat_rdy = act_rd_dat_rdy;
    assign beat           = act_rd_dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
    assign last_beat      = beat && (rcv_cnt == chn_k - 1'b1);

    assign flush_end   = (state == FLUSH) &&
                         (flush_cnt == FLUSH_CNT_WIDTH'(FLUSH_CYCLES - 1));
    assign step        = beat | (state == FLUSH);
    assign zero_in     = (state == FLUSH);
    assign drain_start = flush_end;

    //==========================================================================
    // State machine and counters
    //==========================================================================
    always_comb begin
        case (state)
            IDLE:    state_nxt = cfg_hs ? COMP : IDLE;
            COMP:    state_nxt = last_beat ? FLUSH : COMP;
            FLUSH:   state_nxt = flush_end ? DRAIN : FLUSH;
            DRAIN:   state_nxt = drain_done ? IDLE : DRAIN;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            iss_cnt   <= '0;
            rcv_cnt   <= '0;
            flush_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (cfg_hs) begin
                iss_cnt <= '0;
                rcv_cnt <= '0;
            end else begin
                if (addr_hs) begin
                    iss_cnt <= iss_cnt + 1'b1;
                end
                if (beat) begin
                    rcv_cnt <= rcv_cnt + 1'b1;
                end
            end
            flush_cnt <= (state == FLUSH) ? flush_cnt + 1'b1 : '0;
        end
    end

    // A waiting address pair keeps its request and addresses until accepted
    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        addr_req && !addr_hs |=> addr_req && $stable(act_rd_addr) && $stable(wgt_rd_addr));

    // A real beat always answers an address pair already issued
    a_step_source: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> zero_in || (rcv_cnt < iss_cnt));

endmodule

// File: rtl/sya_drain.sv
//==========================================================================
// Result drain. Walks the array row by row after a flush, applies ReLU
// and requantization, and writes each row to output base plus row.
//==========================================================================
module sya_drain (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              drain_start,
    input  sya_pkg::addr_t                    ofm_base,
    input  sya_isa_pkg::shift_t               shift,
    input  sya_isa_pkg::zp_t                  zp,
    input  sya_pkg::psum_row_t                row_psum,
    output logic [sya_pkg::ROW_SEL_WIDTH-1:0] row_sel,
    output logic                              drain_done,
    output sya_pkg::ofm_row_t                 ofm_wr_dat,
    output sya_pkg::addr_t                    ofm_wr_addr,
    output logic                              ofm_wr_vld,
    input  logic                              ofm_wr_rdy
);
    import sya_pkg::*;

    logic  wr_hs;
    logic  last_row;
    psum_t scaled [NUM_COL];

    assign wr_hs      = ofm_wr_vld & ofm_wr_rdy;
    assign last_row   = (row_sel == ROW_SEL_WIDTH'(NUM_ROW - 1));
    assign drain_done = wr_hs & last_row;

    //==========================================================================
    // ReLU and requantization
    //==========================================================================
    // Negative sums clamp to zero, others keep 8 bits at the shift and add zp
    always_comb begin
        for (int c = 0; c < NUM_COL; c++) begin
            scaled[c] = row_psum[c] >>> shift;
            if (row_psum[c][PSUM_WIDTH-1]) begin
                ofm_wr_dat[c] = '0;
            end else begin
                ofm_wr_dat[c] = scaled[c][ACT_WIDTH-1:0] + zp;
            end
        end
    end

    // Row sequencing, one row per write handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld  <= 1'b0;
            row_sel     <= '0;
            ofm_wr_addr <= '0;
        end else if (drain_start) begin
            ofm_wr_vld  <= 1'b1;
            row_sel     <= '0;
            ofm_wr_addr <= ofm_base;
        end else if (wr_hs) begin
            ofm_wr_vld  <= !last_row;
            row_sel     <= last_row ? '0 : row_sel + 1'b1;
            ofm_wr_addr <= ofm_wr_addr + 1'b1;
        end
    end

    // Frozen array keeps a stalled row unchanged until it is taken
    a_row_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=>
            ofm_wr_vld && $stable(ofm_wr_dat) && $stable(ofm_wr_addr));

endmodule

// File: rtl/sya_isa_pkg.sv
//==========================================================================
// Layout of the configuration word accepted by the engine.
// Fields are packed from the top of the word down.
//==========================================================================
package sya_isa_pkg;

    localparam int SHIFT_WIDTH = 5;
    localparam int ZP_WIDTH    = 8;

    //==========================================================================
    // Field positions, LSB of each field
    //==========================================================================
    // zp sits at the bottom, ofm base at the top
    localparam int ZP_LSB    = 0;
    localparam int SHIFT_LSB = ZP_LSB + ZP_WIDTH;
    localparam int CHN_LSB   = SHIFT_LSB + SHIFT_WIDTH;
    localparam int WGT_LSB   = CHN_LSB + sya_pkg::CHN_WIDTH;
    localparam int ACT_LSB   = WGT_LSB + sya_pkg::ADDR_WIDTH;
    localparam int OFM_LSB   = ACT_LSB + sya_pkg::ADDR_WIDTH;

    // 77 bits with the default widths
    localparam int CFG_WIDTH = OFM_LSB + sya_pkg::ADDR_WIDTH;

    typedef logic [SHIFT_WIDTH-1:0] shift_t;
    typedef logic [ZP_WIDTH-1:0]    zp_t;

endpackage

// File: rtl/sya_pe.sv
//==========================================================================
// Output-stationary processing element. Accumulates one dot product and
// passes the activation east and the weight south, one step per hop.
//==========================================================================
module sya_pe (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          step,
    input  logic          acc_clear,
    input  sya_pkg::act_t act_in,
    input  sya_pkg::wgt_t wgt_in,
    output sya_pkg::act_t act_out,
    output sya_pkg::wgt_t wgt_out,
    output sya_pkg::psum_t psum
);
    import sya_pkg::*;

    psum_t prod;

    // Both operands widened as signed before the multiply
    assign prod = psum_t'(act_in) * psum_t'(wgt_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_out <= '0;
            wgt_out <= '0;
            psum    <= '0;
        end else begin
            if (acc_clear) begin
                psum <= '0;
            end else if (step) begin
                psum <= psum + prod;
            end
            if (step) begin
                act_out <= act_in;
                wgt_out <= wgt_in;
            end
        end
    end

endmodule

// File: rtl/sya_pe_array.sv
//==========================================================================
// NUM_ROW x NUM_COL grid of PEs. Activations enter on the west edge and
// weights on the north edge; one row of sums is read out at a time.
//==========================================================================
module sya_pe_array (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              step,
    input  logic                              acc_clear,
    input  sya_pkg::act_vec_t                 act_w,
    input  sya_pkg::wgt_vec_t                 wgt_n,
    input  logic [sya_pkg::ROW_SEL_WIDTH-1:0] row_sel,
    output sya_pkg::psum_row_t                row_psum
);
    import sya_pkg::*;

    // Extra column and row hold what leaves the east and south edges
    act_t      act_link [NUM_ROW][NUM_COL+1];
    wgt_t      wgt_link [NUM_ROW+1][NUM_COL];
    psum_row_t psum_grid [NUM_ROW];

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_west
        assign act_link[r][0] = act_w[r];
    end

    for (genvar c = 0; c < NUM_COL; c++) begin : g_north
        assign wgt_link[0][c] = wgt_n[c];
    end

    for (genvar r = 0; r < NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .step      (step),
                .acc_clear (acc_clear),
                .act_in    (act_link[r][c]),
                .wgt_in    (wgt_link[r][c]),
                .act_out   (act_link[r][c+1]),
                .wgt_out   (wgt_link[r+1][c]),
                .psum      (psum_grid[r][c])
            );
        end
    end

    assign row_psum = psum_grid[row_sel];

endmodule

// File: rtl/sya_pkg.sv
//==========================================================================
// Geometry, data widths and shared types of the systolic matrix engine.
// Imported by every RTL block and by the testbench.
//==========================================================================
package sya_pkg;

    //==========================================================================
    // Array geometry and widths
    //==========================================================================
    localparam int NUM_ROW       = 4;
    localparam int NUM_COL       = 4;
    localparam int ROW_SEL_WIDTH = $clog2(NUM_ROW);

    localparam int ACT_WIDTH  = 8;
    localparam int WGT_WIDTH  = 8;
    localparam int CHN_WIDTH  = 16;
    // Wide enough for K full-scale products
    localparam int PSUM_WIDTH = ACT_WIDTH + WGT_WIDTH + CHN_WIDTH;
    localparam int ADDR_WIDTH = 16;

    // Zero beats that carry the last real beat into the far corner PE
    localparam int FLUSH_CYCLES = NUM_ROW + NUM_COL - 1;

    //==========================================================================
    // Data types
    //==========================================================================
    typedef logic signed [ACT_WIDTH-1:0]  act_t;
    typedef logic signed [WGT_WIDTH-1:0]  wgt_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    typedef act_t  [NUM_ROW-1:0] act_vec_t;
    typedef wgt_t  [NUM_COL-1:0] wgt_vec_t;
    typedef psum_t [NUM_COL-1:0] psum_row_t;
    typedef logic  [NUM_COL-1:0][ACT_WIDTH-1:0] ofm_row_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [CHN_WIDTH-1:0]  chn_t;

    // Controller sequence, one job per pass
    typedef enum logic [1:0] {
        IDLE,
        COMP,
        FLUSH,
        DRAIN
    } sya_state_e;

endpackage

// File: rtl/sya_skew.sv
//==========================================================================
// Input skew. Activation row r and weight column c are delayed by r and
// c steps so that equal channel indices meet at each PE.
//==========================================================================
module sya_skew (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              step,
    input  logic              zero_in,
    input  sya_pkg::act_vec_t act_in,
    input  sya_pkg::wgt_vec_t wgt_in,
    output sya_pkg::act_vec_t act_w,
    output sya_pkg::wgt_vec_t wgt_n
);
    import sya_pkg::*;

    localparam int LANES = NUM_ROW + NUM_COL;

    // Activation lanes low, weight lanes high, all one byte wide
    logic [LANES-1:0][ACT_WIDTH-1:0] lane_in;
    logic [LANES-1:0][ACT_WIDTH-1:0] lane_out;

    assign lane_in        = zero_in ? '0 : {wgt_in, act_in};
    assign {wgt_n, act_w} = lane_out;

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        localparam int DEPTH = (i < NUM_ROW) ? i : i - NUM_ROW;
        if (DEPTH == 0) begin : g_direct
            assign lane_out[i] = lane_in[i];
        end else begin : g_delay
            logic [ACT_WIDTH-1:0] taps [DEPTH];
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < DEPTH; s++) begin
                        taps[s] <= '0;
                    end
                end else if (step) begin
                    taps[0] <= lane_in[i];
                    for (int s = 1; s < DEPTH; s++) begin
                        taps[s] <= taps[s-1];
                    end
                end
            end
            assign lane_out[i] = taps[DEPTH-1];
        end
    end

endmodule

// File: rtl/sya_top.sv
//==========================================================================
// Systolic matrix engine top level. Joins the controller, input skew,
// PE array and drain; the global buffer sits outside.
//==========================================================================
module sya_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_vld,
    output logic                              cfg_rdy,
    input  logic [sya_isa_pkg::CFG_WIDTH-1:0] cfg_info,
    output sya_pkg::addr_t                    act_rd_addr,
    output logic                              act_rd_addr_vld,
    input  logic                              act_rd_addr_rdy,
    output sya_pkg::addr_t                    wgt_rd_addr,
    output logic                              wgt_rd_addr_vld,
    input  logic                              wgt_rd_addr_rdy,
    input  sya_pkg::act_vec_t                 act_rd_dat,
    input  logic                              act_rd_dat_vld,
    output logic                              act_rd_dat_rdy,
    input  sya_pkg::wgt_vec_t                 wgt_rd_dat,
    input  logic                              wgt_rd_dat_vld,
    output logic                              wgt_rd_dat_rdy,
    output sya_pkg::ofm_row_t                 ofm_wr_dat,
    output sya_pkg::addr_t                    ofm_wr_addr,
    output logic                              ofm_wr_vld,
    input  logic                              ofm_wr_rdy
);
    import sya_pkg::*;
    import sya_isa_pkg::*;

    logic                     step;
    logic                     zero_in;
    logic                     acc_clear;
    logic                     drain_start;
    logic                     drain_done;
    addr_t                    ofm_base;
    shift_t                   shift;
    zp_t                      zp;
    act_vec_t                 act_w;
    wgt_vec_t                 wgt_n;
    logic [ROW_SEL_WIDTH-1:0] row_sel;
    psum_row_t                row_psum;

    sya_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_info        (cfg_info),
        .act_rd_addr     (act_rd_addr),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .act_rd_dat_rdy  (act_rd_dat_rdy),
        .wgt_rd_dat_rdy  (wgt_rd_dat_rdy),
        .step            (step),
        .zero_in         (zero_in),
        .acc_clear       (acc_clear),
        .drain_start     (drain_start),
        .drain_done      (drain_done),
        .ofm_base        (ofm_base),
        .shift           (shift),
        .zp              (zp)
    );

    sya_skew u_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .zero_in (zero_in),
        .act_in  (act_rd_dat),
        .wgt_in  (wgt_rd_dat),
        .act_w   (act_w),
        .wgt_n   (wgt_n)
    );

    sya_pe_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .acc_clear (acc_clear),
        .act_w     (act_w),
        .wgt_n     (wgt_n),
        .row_sel   (row_sel),
        .row_psum  (row_psum)
    );

    sya_drain u_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_start (drain_start),
        .ofm_base    (ofm_base),
        .shift       (shift),
        .zp          (zp),
        .row_psum    (row_psum),
        .row_sel     (row_sel),
        .drain_done  (drain_done),
        .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy)
    );

endmodule

// File: sources.f
+incdir+bench
rtl/sya_pkg.sv
rtl/sya_isa_pkg.sv
rtl/sya_pe.sv
rtl/sya_pe_array.sv
rtl/sya_skew.sv
rtl/sya_ctrl.sv
rtl/sya_drain.sv
rtl/sya_top.sv
bench/sya_tb.sv
